// ==== common/nocPkg.sv ====
`default_nettype none

package nocPkg;

  // Router inputs in index order Local, North, East, West, South
  localparam int numPorts = 5;

  localparam int flitWidth = 32;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int tagWidth = flitWidth - flitIdWidth - lengthWidth;
  localparam int payloadWidth = flitWidth - flitIdWidth;

  localparam logic [flitIdWidth-1:0] flitIdHead = 3'd1;
  localparam logic [flitIdWidth-1:0] flitIdBody = 3'd2;
  localparam logic [flitIdWidth-1:0] flitIdTail = 3'd4;

  // A head flit carries the packet length and the destination tag
  // Body and tail flits carry payload only, behind the same id field
  typedef union packed {
    struct packed {
      logic [flitIdWidth-1:0] flitId;
      logic [lengthWidth-1:0] length;
      logic [tagWidth-1:0]    destTag;
    } head;
    struct packed {
      logic [flitIdWidth-1:0]  flitId;
      logic [payloadWidth-1:0] payload;
    } body;
  } flitU;

endpackage

`default_nettype wire

// ==== rtl/flitFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flitFifo
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  flitU inFlit,
  input  logic pop,
  output logic inReady,
  output logic notEmpty,
  output flitU headFlit
);

  localparam int addrWidth = $clog2(fifoDepth);

  flitU mem [fifoDepth];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [addrWidth:0] wrPtr;
  logic [addrWidth:0] rdPtr;
  logic               full;
  logic               push;
  logic               popEn;

  assign full = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
                (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

  assign inReady  = !full;
  assign notEmpty = (wrPtr != rdPtr);
  assign push     = inValid && inReady;
  assign popEn    = pop && notEmpty;

  // Head comes straight from storage, valid together with notEmpty
  assign headFlit = mem[rdPtr[addrWidth-1:0]];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr[addrWidth-1:0]] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (popEn)
        rdPtr <= rdPtr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== arbiter/grantTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module grantTimer
  import nocPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic runTimer,
  input  logic headLoad,
  input  logic clearCount,
  input  flitU headFlit,
  output logic timesUp
);

  // Budget is in flits sent per grant, not in clock cycles
  logic [lengthWidth-1:0] budget;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (headLoad)
        budget <= headFlit.head.length;

      // A head flit starts a new packet, and it is itself the first flit sent
      if (clearCount)
        count <= '0;
      else if (headLoad)
        count <= lengthWidth'(1);
      else if (runTimer)
        count <= count + 1'b1;
    end
  end

  assign timesUp = (count != '0) && (count == budget);

endmodule

`default_nettype wire

// ==== arbiter/outputArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import nocPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] notEmpty,
  input  flitU                headFlit [numPorts],
  input  logic [numPorts-1:0] timesUp,
  input  logic                outReady,
  output logic [numPorts-1:0] pop,
  output logic [numPorts-1:0] runTimer,
  output logic [numPorts-1:0] headLoad,
  output logic [numPorts-1:0] clearCount,
  output logic                outValid,
  output flitU                outFlit
);

  // Bit 0 is idle, bit p+1 grants port p
  localparam int stateWidth = numPorts + 1;
  localparam logic [stateWidth-1:0] stateIdle = stateWidth'(1);

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0]   grant;
  logic                  transfer;

  // First requester among count ports, walking the rotation from port first
  function automatic logic [stateWidth-1:0] pickFrom
  (
    input logic [numPorts-1:0] req,
    input int                  first,
    input int                  count
  );
    logic [stateWidth-1:0] result;
    logic                  found;
    int                    idx;
    result = stateIdle;
    found  = 1'b0;
    for (int k = 0; k < numPorts; k++)
    begin
      idx = (first + k) % numPorts;
      if (!found && (k < count) && req[idx])
      begin
        result          = '0;
        result[idx + 1] = 1'b1;
        found           = 1'b1;
      end
    end
    return result;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = stateIdle;
    // Idle scans in fixed order starting at Local
    if (state[0])
      nextState = pickFrom(notEmpty, 0, numPorts);
    for (int p = 0; p < numPorts; p++)
    begin
      if (state[p + 1])
      begin
        if (notEmpty[p] && !timesUp[p])
        begin
          nextState        = '0;
          nextState[p + 1] = 1'b1;
        end
        else
          nextState = pickFrom(notEmpty, p + 1, numPorts - 1);
      end
    end
  end

  assign grant = state[stateWidth-1:1];

  // An owner whose budget is spent sends nothing more before it lets go
  always_comb
  begin
    outFlit  = '0;
    outValid = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        outFlit  = headFlit[i];
        outValid = notEmpty[i] && !timesUp[i];
      end
    end
  end

  assign transfer = outValid && outReady;

  assign pop        = grant & {numPorts{transfer}};
  assign runTimer   = pop;
  assign clearCount = grant & ~nextState[stateWidth-1:1];

  always_comb
  begin
    for (int i = 0; i < numPorts; i++)
      headLoad[i] = pop[i] && (headFlit[i].head.flitId == flitIdHead);
  end

endmodule

`default_nettype wire

// ==== rtl/routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] inValid,
  input  flitU                inFlit [numPorts],
  input  logic                outReady,
  output logic [numPorts-1:0] inReady,
  output logic                outValid,
  output flitU                outFlit
);

  logic [numPorts-1:0] notEmpty;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] runTimer;
  logic [numPorts-1:0] headLoad;
  logic [numPorts-1:0] clearCount;
  logic [numPorts-1:0] timesUp;
  flitU                headFlit [numPorts];

  // One buffer and one flit budget per input
  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    flitFifo #(
      .fifoDepth (fifoDepth)
    ) uFifo (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[i]),
      .inFlit   (inFlit[i]),
      .pop      (pop[i]),
      .inReady  (inReady[i]),
      .notEmpty (notEmpty[i]),
      .headFlit (headFlit[i])
    );

    grantTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .runTimer   (runTimer[i]),
      .headLoad   (headLoad[i]),
      .clearCount (clearCount[i]),
      .headFlit   (headFlit[i]),
      .timesUp    (timesUp[i])
    );
  end

  outputArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .notEmpty   (notEmpty),
    .headFlit   (headFlit),
    .timesUp    (timesUp),
    .outReady   (outReady),
    .pop        (pop),
    .runTimer   (runTimer),
    .headLoad   (headLoad),
    .clearCount (clearCount),
    .outValid   (outValid),
    .outFlit    (outFlit)
  );

endmodule

`default_nettype wire

// ==== tb/tbRouterOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort
  import nocPkg::*;
();

  localparam int clkPeriod     = 8;
  localparam int resetCycles   = 16;
  localparam int fifoDepth     = 4;
  localparam int caseWords     = 512;
  localparam int maxFlits      = 16;
  localparam int maxExpected   = 64;
  localparam int cyclesPerFlit = 20;
  localparam int quietCycles   = 10;

  // Back-pressure modes of the case file
  localparam int modeRandom = 1;
  localparam int modeFill   = 2;
  localparam int modeReset  = 3;

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  flitU                inFlit [numPorts];
  logic                outReady;
  logic [numPorts-1:0] inReady;
  logic                outValid;
  flitU                outFlit;

  logic [31:0] caseMem [caseWords];
  int          casePos;
  int          numTests;
  flitU        portFlits [numPorts][maxFlits];
  int          portCount [numPorts];
  flitU        expFlits [maxExpected];
  int          expPorts [maxExpected];
  int          expCount;
  int          testId;
  int          preload;
  int          mode;
  int          rcvCount;
  int          testErrors;
  int          passCount;
  int          failCount;
  int          watchdogCycles;
  logic [31:0] lcgState;
  logic        stallSeen;
  flitU        stallFlit;

  routerOutputPort #(
    .fifoDepth (fifoDepth)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .outReady (outReady),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] readWord();
    logic [31:0] word;
    word    = caseMem[casePos];
    casePos = casePos + 1;
    return word;
  endfunction

  // Walks the whole case file and adds up the input flits of every test
  function automatic int countCaseFlits();
    int pos;
    int total;
    int n;
    pos   = 1;
    total = 0;
    for (int t = 0; t < numTests; t++)
    begin
      pos = pos + 3;
      for (int p = 0; p < numPorts; p++)
      begin
        n     = caseMem[pos];
        total = total + n;
        pos   = pos + 1 + n;
      end
      n   = caseMem[pos];
      pos = pos + 1 + 2 * n;
    end
    return total;
  endfunction

  task automatic loadTest();
    testId  = readWord();
    preload = readWord();
    mode    = readWord();
    for (int p = 0; p < numPorts; p++)
    begin
      portCount[p] = readWord();
      for (int k = 0; k < portCount[p]; k++)
        portFlits[p][k] = readWord();
    end
    expCount = readWord();
    for (int k = 0; k < expCount; k++)
    begin
      expPorts[k] = readWord();
      expFlits[k] = readWord();
    end
  endtask

  task automatic sendFlits();
    int   sent [numPorts];
    logic pending;
    for (int p = 0; p < numPorts; p++)
      sent[p] = 0;
    do
    begin
      @(negedge clk);
      // A flit offered while inReady is high is taken at the coming edge
      for (int p = 0; p < numPorts; p++)
        if (inValid[p] && inReady[p])
          sent[p] = sent[p] + 1;
      @(posedge clk);
      pending = 1'b0;
      for (int p = 0; p < numPorts; p++)
      begin
        if (sent[p] < portCount[p])
        begin
          inValid[p] <= 1'b1;
          inFlit[p]  <= portFlits[p][sent[p]];
          pending    = 1'b1;
        end
        else
          inValid[p] <= 1'b0;
      end
    end
    while (pending);
  endtask

  task automatic checkReset();
    @(negedge clk);
    assert (!outValid)
    else
    begin
      $display("[FAIL] %t: outValid is high right after reset", $time);
      testErrors++;
    end
    assert (inReady == '1)
    else
    begin
      $display("[FAIL] %t: inReady is %b after reset, expected all high", $time, inReady);
      testErrors++;
    end
  endtask

  task automatic checkFill();
    int port;
    int waited;
    port = 0;
    for (int p = numPorts - 1; p >= 0; p--)
      if (portCount[p] > 0)
        port = p;
    @(negedge clk);
    assert (!inReady[port])
    else
    begin
      $display("[FAIL] %t: inReady of port %0d is high with a full FIFO", $time, port);
      testErrors++;
    end
    @(posedge clk);
    outReady <= 1'b1;
    waited = 0;
    do
    begin
      @(negedge clk);
      waited++;
    end
    while (!(outValid && outReady) && waited < cyclesPerFlit);
    @(negedge clk);
    assert (inReady[port])
    else
    begin
      $display("[FAIL] %t: inReady of port %0d stays low after a pop", $time, port);
      testErrors++;
    end
  endtask

  task automatic drainOutput();
    int limit;
    int waited;
    limit  = expCount * cyclesPerFlit + cyclesPerFlit;
    waited = 0;
    while (rcvCount < expCount && waited < limit)
    begin
      @(posedge clk);
      if (mode == modeRandom)
      begin
        lcgState = lcgNext(lcgState);
        outReady <= lcgState[16];
      end
      else
        outReady <= 1'b1;
      waited++;
    end
    if (rcvCount < expCount)
    begin
      $display("Test %0d: only %0d of %0d expected flits reached the output",
               testId, rcvCount, expCount);
      testErrors++;
    end
    // Keep the link open so that a stray flit shows up
    repeat (quietCycles)
    begin
      @(posedge clk);
      outReady <= 1'b1;
    end
  endtask

  task automatic runTest();
    loadTest();
    rcvCount   = 0;
    testErrors = 0;
    @(posedge clk);
    outReady <= (preload != 0 || mode == modeFill) ? 1'b0 : 1'b1;
    if (mode == modeReset)
      checkReset();
    sendFlits();
    if (mode == modeFill)
      checkFill();
    drainOutput();
    if (testErrors == 0)
    begin
      $display("Test %0d passed with %0d flits", testId, rcvCount);
      passCount++;
    end
    else
    begin
      $display("Test %0d failed with %0d errors", testId, testErrors);
      failCount++;
    end
  endtask

  // Every transfer happens at the edge after a negedge where both handshake lines are high
  always @(negedge clk)
  begin
    if (!rst && stallSeen)
    begin
      assert (outValid && (outFlit == stallFlit))
      else
      begin
        $display("[FAIL] %t: output flit changed while the link was stalled", $time);
        testErrors++;
      end
    end
    if (!rst && outValid && outReady)
    begin
      if (rcvCount < expCount)
      begin
        assert (outFlit == expFlits[rcvCount])
        else
        begin
          $display("[FAIL] %t: flit %0d is %h, expected %h from port %0d", $time,
                   rcvCount, outFlit, expFlits[rcvCount], expPorts[rcvCount]);
          testErrors++;
        end
      end
      else
      begin
        $display("Test %0d: an extra flit %h left the output after the expected sequence",
                 testId, outFlit);
        testErrors++;
      end
      rcvCount++;
    end
    stallSeen = !rst && outValid && !outReady;
    stallFlit = outFlit;
  end

  initial
  begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with tests still running", watchdogCycles);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    $timeformat(-9, 0, " ns", 8);
    rst            = 1'b1;
    inValid        = '0;
    outReady       = 1'b0;
    for (int p = 0; p < numPorts; p++)
      inFlit[p] = '0;
    rcvCount       = 0;
    expCount       = 0;
    testErrors     = 0;
    passCount      = 0;
    failCount      = 0;
    testId         = 0;
    stallSeen      = 1'b0;
    stallFlit      = '0;
    watchdogCycles = 0;
    lcgState       = 32'd43;
    casePos        = 1;
    $readmemh("tb/arbiterCases.txt", caseMem);
    numTests = $isunknown(caseMem[0]) ? 0 : caseMem[0];
    if (numTests == 0)
    begin
      $display("The case file tb/arbiterCases.txt could not be read");
      $display("Some tests failed");
    end
    else
    begin
      watchdogCycles = countCaseFlits() * cyclesPerFlit + resetCycles;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      for (int t = 0; t < numTests; t++)
        runTest();
      $display("Passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0)
        $display("All tests passed");
      else
        $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/arbiterCases.txt ====
// All fields are hex. The first word is the number of tests
// Per test: id preload mode, then per port L N E W S a count and its flits,
// then the expected count and one port and flit pair per output transfer
// Modes: 0 outReady high, 1 random outReady, 2 fill one FIFO, 3 reset state
6

// Test 1 checks the state right after reset
1 0 3
0
0
0
0
0
0

// Test 2 sends one North packet of three flits
2 0 0
0
3 20060201 40000202 80000203
0
0
0
3
1 20060201  1 40000202  1 80000203

// Test 3 preloads all five ports
3 1 0
2 20040301 80000302
3 20060311 40000312 80000313
4 20080321 40000322 40000323 80000324
1 20020331
2 20040341 80000342
0c
0 20040301  0 80000302
1 20060311  1 40000312  1 80000313
2 20080321  2 40000322  2 40000323  2 80000324
3 20020331
4 20040341  4 80000342

// Test 4 has an East length of 2 for four flits
4 1 0
0
0
4 20040421 40000422 40000423 80000424
2 20040431 80000432
3 20060441 40000442 80000443
09
2 20040421  2 40000422
3 20040431  3 80000432
4 20060441  4 40000442  4 80000443
2 40000423  2 80000424

// Test 5 repeats test 3 under random back-pressure
5 1 1
2 20040301 80000302
3 20060311 40000312 80000313
4 20080321 40000322 40000323 80000324
1 20020331
2 20040341 80000342
0c
0 20040301  0 80000302
1 20060311  1 40000312  1 80000313
2 20080321  2 40000322  2 40000323  2 80000324
3 20020331
4 20040341  4 80000342

// Test 6 fills the West FIFO while the output is stalled
6 1 2
0
0
0
4 20080631 40000632 40000633 80000634
0
4
3 20080631  3 40000632  3 40000633  3 80000634

// ==== sources.f ====
common/nocPkg.sv
rtl/flitFifo.sv
arbiter/grantTimer.sv
arbiter/outputArbiter.sv
rtl/routerOutputPort.sv
tb/tbRouterOutputPort.sv

// ==== Bender.yml ====
package:
  name: router_output_port

sources:
  # Shared package first, then the blocks, then the top level
  - common/nocPkg.sv
  - rtl/flitFifo.sv
  - arbiter/grantTimer.sv
  - arbiter/outputArbiter.sv
  - rtl/routerOutputPort.sv

  - target: test
    files:
      - tb/tbRouterOutputPort.sv
